// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = radio_ctrl_tb
FILELIST  = build.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -o $(TOP)
	./obj_dir/$(TOP) 2>&1 | tee $(LOG)
	grep -q 'All tests passed!' $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== build.f ====
+incdir+include
verilog/radio_ctrl_pkg.sv
verilog/led_ctrl_if.sv
verilog/radio_reg_block.sv
verilog/capture_fsm.sv
verilog/sample_buffer.sv
verilog/led_pwm.sv
verilog/irq_ctrl.sv
verilog/radio_ctrl_top.sv
verification/radio_ctrl_tb.sv

// ==== include/radio_ctrl_defs.svh ====
`ifndef RADIO_CTRL_DEFS_SVH
`define RADIO_CTRL_DEFS_SVH

// Snapshot buffer and datapath sizes
`define RADIO_BUF_ASZ       12              // 4096 words
`define RADIO_SAMPLE_W      16
`define RADIO_PWM_W         12
`define RADIO_IRQ_COUNT     8

`define RADIO_CHIP_ID       32'hDADC0001

// Register map
`define REG_ID              7'h00
`define REG_IRQ             7'h02
`define REG_LED_CNTRL       7'h10
`define REG_RED_DUTY        7'h11
`define REG_GREEN_DUTY      7'h12
`define REG_BLUE_DUTY       7'h13
`define REG_BUF_CNTRL       7'h20
`define REG_BUF_ADDR        7'h21
`define REG_BUF_DATA        7'h22

`endif

// ==== verification/radio_ctrl_stimulus.txt ====
// Columns: op addr value expected, all hex
// op 1 write, 2 read-check (value is mask), 3 capture (addr start, value ctrl, expected reads)
// op 4 pwm high cycles (addr 0 red, 1 green, 2 blue), 5 irq pin (0 smc, 1 dsp), 6 overflow, 0 end
2 00 FFFFFFFF DADC0001
2 02 FFFFFFFF 00000000
2 10 FFFFFFFF 00000000
2 11 FFFFFFFF 00000000
2 20 FFFFFFFF 00000000
2 21 FFFFFFFF 00000000
2 7F FFFFFFFF 00000000
1 10 00000005 00000000
1 11 00000400 00000000
1 12 00000123 00000000
2 10 FFFFFFFF 00000005
2 11 FFFFFFFF 00000400
2 12 FFFFFFFF 00000123
1 02 0000A55A 00000000
2 02 FFFFFFFF 0000A55A
1 02 00000000 00000000
4 00 00000000 00000400
4 01 00000000 00000000
4 02 00000000 00000000
3 7F0 00000003 00000008
2 20 FFFFFFFF 00000002
2 02 00FF0000 00030000
1 02 00000002 00000000
5 00 00000000 00000000
1 02 00020002 00000000
5 00 00000000 00000001
2 02 FFFFFFFF 00010002
6 00 00000000 00000000
2 02 FFFFFFFF 00050002
1 02 20002000 00000000
5 01 00000000 00000000
5 00 00000000 00000001
2 02 FFFFFFFF 00252000
0 00 00000000 00000000

// ==== verification/radio_ctrl_tb.sv ====
`timescale 1ns/10ps

`include "radio_ctrl_defs.svh"

module radio_ctrl_tb;

import radio_ctrl_pkg::*;

localparam int RESET_CYCLES = 10;
localparam int BUF_WORDS    = 1 << `RADIO_BUF_ASZ;
localparam int PWM_PERIOD   = 1 << `RADIO_PWM_W;
localparam int CYCLE_LIMIT  = RESET_CYCLES + 5 * BUF_WORDS + 16 * PWM_PERIOD;
localparam int MAX_OPS      = 64;

logic                         led_clk;
logic                         adc_dpram_rst;
reg_addr_t                    reg_addr;
reg_data_t                    reg_wdata;
logic                         reg_wr_en;
logic                         reg_rd_en;
logic [`RADIO_SAMPLE_W - 1:0] adc_data;
logic                         adc_of;
reg_data_t                    reg_rdata;
logic                         red_led;
logic                         green_led;
logic                         blue_led;
logic                         smc_irq_n;
logic                         dsp_irq_n;

logic [31:0] stim [0:4 * MAX_OPS - 1]; // Four words per operation
logic [31:0] rng;
int          cycles = 0;
int          errors = 0;
int          checks = 0;

radio_ctrl_top radio_ctrl_top_inst
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_wr_en(reg_wr_en),
    .reg_rd_en(reg_rd_en),
    .adc_data(adc_data),
    .adc_of(adc_of),
    .reg_rdata(reg_rdata),
    .red_led(red_led),
    .green_led(green_led),
    .blue_led(blue_led),
    .smc_irq_n(smc_irq_n),
    .dsp_irq_n(dsp_irq_n)
);

initial
    begin
        led_clk = 1'b0;
        forever #5 led_clk = ~led_clk;
    end

// ADC ramp with one step per clock
initial
    begin
        adc_data = '0;
        forever
            begin
                @(negedge led_clk);
                adc_data = adc_data + 1'b1;
            end
    end

always @(posedge led_clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT)
            begin
                $display("Timeout after %0d cycles, the test sequence did not finish", cycles);
                $display("Test failures found");
                $finish;
            end
    end

function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
endfunction

task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp)
        begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
endtask

task automatic write_reg(input logic [6:0] addr, input logic [31:0] data);
    reg_addr  = addr;
    reg_wdata = data;
    reg_wr_en = 1'b1;
    @(negedge led_clk);
    reg_wr_en = 1'b0;
endtask

task automatic read_reg(input logic [6:0] addr, output logic [31:0] data);
    reg_addr  = addr;
    reg_rd_en = 1'b1;
    @(negedge led_clk);
    reg_rd_en = 1'b0;
    data      = reg_rdata; // Registered at the strobe edge
endtask

task automatic run_capture(input logic [31:0] start, input logic [31:0] ctrl, input int reads);
    logic [31:0] word;
    logic [15:0] prev;
    int          polls;
    write_reg(`REG_BUF_CNTRL, ctrl);
    word  = '0;
    prev  = '0;
    polls = 0;
    while (!word[2] && polls < 16)
        begin
            read_reg(`REG_BUF_CNTRL, word);
            polls++;
        end
    if (!word[2])
        begin
            errors++;
            $display("Capturing bit did not rise after arming");
        end
    polls = 0;
    while (word[2] && polls < BUF_WORDS + 16)
        begin
            read_reg(`REG_BUF_CNTRL, word);
            polls++;
        end
    if (word[2])
        begin
            errors++;
            $display("Capture did not finish within one buffer length");
        end
    write_reg(`REG_BUF_ADDR, start);
    for (int i = 0; i < reads; i++)
        begin
            read_reg(`REG_BUF_DATA, word);
            if ($isunknown(word[16:0]))
                begin
                    errors++;
                    $display("Buffer word %0d read back with unknown bits", i);
                end
            check_value("buf_overflow", {31'd0, word[16]}, 32'd0); // No overflow while filling
            if (i > 0)
                check_value("buf_sample", {16'd0, word[15:0]}, {16'd0, prev + 16'd1});
            prev = word[15:0];
        end
    read_reg(`REG_BUF_ADDR, word);
    check_value("buf_rd_addr", {20'd0, word[11:0]}, (start + reads) & (BUF_WORDS - 1));
endtask

task automatic measure_pwm(input logic [31:0] led, input logic [31:0] exp);
    logic [2:0] leds;
    int         high;
    high = 0;
    repeat (PWM_PERIOD) @(negedge led_clk); // Old duty may still show in this period
    for (int i = 0; i < PWM_PERIOD; i++)
        begin
            @(negedge led_clk);
            leds = {blue_led, green_led, red_led};
            if (leds[led[1:0]])
                high++;
        end
    case (led[1:0])
        2'd0:    check_value("red_led", high, exp);
        2'd1:    check_value("green_led", high, exp);
        default: check_value("blue_led", high, exp);
    endcase
endtask

task automatic check_irq_pin(input logic [31:0] pin, input logic [31:0] exp);
    repeat (2) @(negedge led_clk); // State follows the request by one cycle
    if (pin == 0)
        check_value("smc_irq_n", {31'd0, smc_irq_n}, exp);
    else
        check_value("dsp_irq_n", {31'd0, dsp_irq_n}, exp);
endtask

task automatic inject_overflow();
    rng = xorshift32(rng);
    repeat (int'(rng[4:0]) + 1) @(negedge led_clk);
    adc_of = 1'b1;
    @(negedge led_clk);
    adc_of = 1'b0;
    repeat (2) @(negedge led_clk); // Through the input register and edge detector
endtask

initial
    begin
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] value;
        logic [31:0] exp_val;
        logic [31:0] rdata;
        int          idx;
        int          tests;
        int          failed;
        int          errs_before;
        bit          done;

        adc_dpram_rst = 1'b1;
        reg_addr      = '0;
        reg_wdata     = '0;
        reg_wr_en     = 1'b0;
        reg_rd_en     = 1'b0;
        adc_of        = 1'b0;
        rng           = 32'h8fbe_840b;
        $readmemh("verification/radio_ctrl_stimulus.txt", stim);

        repeat (RESET_CYCLES) @(negedge led_clk);
        adc_dpram_rst = 1'b0;
        @(negedge led_clk);

        idx    = 0;
        tests  = 0;
        failed = 0;
        done   = 1'b0;
        while (!done && idx < MAX_OPS)
            begin
                op      = stim[4 * idx];
                addr    = stim[4 * idx + 1];
                value   = stim[4 * idx + 2];
                exp_val = stim[4 * idx + 3];
                if ($isunknown(op) || op == 0)
                    done = 1'b1;
                else
                    begin
                        errs_before = errors;
                        case (op)
                            1: write_reg(addr[6:0], value);
                            2:
                                begin
                                    read_reg(addr[6:0], rdata);
                                    check_value($sformatf("reg_rdata[%h]", addr[6:0]),
                                                rdata & value, exp_val); // Value is the mask
                                end
                            3: run_capture(addr, value, exp_val);
                            4: measure_pwm(addr, exp_val);
                            5: check_irq_pin(addr, exp_val);
                            6: inject_overflow();
                            default:
                                begin
                                    errors++;
                                    $display("Unknown operation %h on stimulus entry %0d", op, idx);
                                end
                        endcase
                        tests++;
                        if (errors != errs_before)
                            failed++;
                        $display("Test %0d: op %0h addr %h %s", idx, op, addr[11:0],
                                 (errors == errs_before) ? "ok" : "failed");
                        idx++;
                    end
            end

        if (tests == 0)
            begin
                errors++;
                $display("No operations were read from the stimulus file");
            end

        $display("Tests run %0d, tests failed %0d, checks %0d, mismatches %0d",
                 tests, failed, checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

// ==== verilog/capture_fsm.sv ====
`timescale 1ns/10ps

module capture_fsm
(
    input  logic                        led_clk,
    input  logic                        adc_dpram_rst,
    input  logic                        arm,
    output logic                        capturing,
    output radio_ctrl_pkg::buf_addr_t   wr_addr,
    output logic                        wr_en
);

import radio_ctrl_pkg::*;

typedef enum logic {IDLE, FILLING} cap_state_t;

cap_state_t state;

always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            begin
                state   <= IDLE;
                wr_addr <= '0;
            end
        else
            begin
                case (state)
                    IDLE:
                        begin
                            wr_addr <= '0;

                            if (arm)
                                state <= FILLING;
                        end
                    FILLING:
                        begin
                            wr_addr <= wr_addr + 1'b1; // Wraps back to zero at the end

                            if (wr_addr == '1) // Last word written this cycle
                                state <= IDLE;
                        end
                    default: state <= IDLE;
                endcase
            end
    end

assign capturing = (state == FILLING);
assign wr_en     = capturing; // One write per filling cycle

endmodule

// ==== verilog/irq_ctrl.sv ====
`timescale 1ns/10ps

`include "radio_ctrl_defs.svh"

module irq_ctrl
(
    input  logic                        led_clk,
    input  logic                        adc_dpram_rst,
    input  logic                        capturing,
    input  logic                        adc_of_q,
    input  radio_ctrl_pkg::irq_vec_t    irq_set,
    input  radio_ctrl_pkg::irq_vec_t    irq_clear,
    input  radio_ctrl_pkg::irq_vec_t    smc_mask,
    input  radio_ctrl_pkg::irq_vec_t    dsp_mask,
    output radio_ctrl_pkg::irq_vec_t    irq_state,
    output logic                        smc_irq_n,
    output logic                        dsp_irq_n
);

import radio_ctrl_pkg::*;

irq_vec_t irq_lines;
irq_vec_t lines_q;  // Previous line levels

// Lines 0 to 2 are capture start, capture done and ADC overflow
assign irq_lines = {{(`RADIO_IRQ_COUNT - 3){1'b0}}, adc_of_q, ~capturing, capturing};

// Follows the lines while reset is held too
always_ff @(posedge led_clk)
    lines_q <= irq_lines;

always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            irq_state <= '0;
        else
            irq_state <= (irq_state & ~irq_clear) | (irq_lines & ~lines_q) | irq_set;
    end

assign smc_irq_n = ~|(irq_state & smc_mask);
assign dsp_irq_n = ~|(irq_state & dsp_mask);

endmodule

// ==== verilog/led_ctrl_if.sv ====
`timescale 1ns/10ps

`include "radio_ctrl_defs.svh"

interface led_ctrl_if;

logic [2:0]                 led_en;     // Blue, green, red
logic [`RADIO_PWM_W - 1:0]  red_duty;
logic [`RADIO_PWM_W - 1:0]  green_duty;
logic [`RADIO_PWM_W - 1:0]  blue_duty;

modport reg_side (output led_en, red_duty, green_duty, blue_duty);
modport pwm_side (input led_en, red_duty, green_duty, blue_duty);

endinterface

// ==== verilog/led_pwm.sv ====
`timescale 1ns/10ps

module led_pwm
(
    input  logic        led_clk,
    input  logic        adc_dpram_rst,
    led_ctrl_if.pwm_side led,
    output logic        red_led,
    output logic        green_led,
    output logic        blue_led
);

import radio_ctrl_pkg::*;

pwm_val_t   pwm_cnt;
pwm_val_t   duty [3];
logic [2:0] led_on;

assign duty[0] = led.red_duty;
assign duty[1] = led.green_duty;
assign duty[2] = led.blue_duty;

always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            begin
                pwm_cnt <= '0;
                led_on  <= 3'b000;
            end
        else
            begin
                pwm_cnt <= pwm_cnt + 1'b1; // Free running over a 4096 cycle period

                for (int i = 0; i < 3; i++)
                    begin
                        if (duty[i] == '0)
                            led_on[i] <= 1'b0; // Zero duty keeps the channel dark
                        else if (pwm_cnt == '0)
                            led_on[i] <= 1'b1;
                        else if (pwm_cnt == duty[i])
                            led_on[i] <= 1'b0;
                    end
            end
    end

assign red_led   = led_on[0] & led.led_en[0];
assign green_led = led_on[1] & led.led_en[1];
assign blue_led  = led_on[2] & led.led_en[2];

endmodule

// ==== verilog/radio_ctrl_pkg.sv ====
`include "radio_ctrl_defs.svh"

package radio_ctrl_pkg;

// Register bus
typedef logic [6:0]                     reg_addr_t;
typedef logic [31:0]                    reg_data_t;

// Snapshot buffer address and stored word
typedef logic [`RADIO_BUF_ASZ - 1:0]    buf_addr_t;
typedef logic [`RADIO_SAMPLE_W:0]       buf_word_t;  // Overflow flag on top of the sample

// PWM duty and count
typedef logic [`RADIO_PWM_W - 1:0]      pwm_val_t;

// One bit per interrupt line
typedef logic [`RADIO_IRQ_COUNT - 1:0]  irq_vec_t;

endpackage

// ==== verilog/radio_ctrl_top.sv ====
`timescale 1ns/10ps

`include "radio_ctrl_defs.svh"

module radio_ctrl_top
(
    input  logic                        led_clk,
    input  logic                        adc_dpram_rst,
    input  radio_ctrl_pkg::reg_addr_t   reg_addr,
    input  radio_ctrl_pkg::reg_data_t   reg_wdata,
    input  logic                        reg_wr_en,
    input  logic                        reg_rd_en,
    input  logic [`RADIO_SAMPLE_W - 1:0] adc_data,
    input  logic                        adc_of,
    output radio_ctrl_pkg::reg_data_t   reg_rdata,
    output logic                        red_led,
    output logic                        green_led,
    output logic                        blue_led,
    output logic                        smc_irq_n,
    output logic                        dsp_irq_n
);

import radio_ctrl_pkg::*;

logic      arm;
logic      capturing;
logic      buf_wr_en;
logic      adc_of_q;
buf_addr_t buf_wr_addr;
buf_addr_t buf_rd_addr;
buf_word_t buf_rdata;
irq_vec_t  irq_state;
irq_vec_t  irq_set;
irq_vec_t  irq_clear;
irq_vec_t  smc_mask;
irq_vec_t  dsp_mask;

led_ctrl_if led_bus ();

radio_reg_block radio_reg_block_inst
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .reg_addr(reg_addr),
    .reg_wdata(reg_wdata),
    .reg_wr_en(reg_wr_en),
    .reg_rd_en(reg_rd_en),
    .capturing(capturing),
    .buf_wr_addr(buf_wr_addr),
    .buf_rdata(buf_rdata),
    .irq_state(irq_state),
    .reg_rdata(reg_rdata),
    .arm(arm),
    .buf_rd_addr(buf_rd_addr),
    .smc_mask(smc_mask),
    .dsp_mask(dsp_mask),
    .irq_set(irq_set),
    .irq_clear(irq_clear),
    .led(led_bus.reg_side)
);

capture_fsm capture_fsm_inst
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .arm(arm),
    .capturing(capturing),
    .wr_addr(buf_wr_addr),
    .wr_en(buf_wr_en)
);

sample_buffer sample_buffer_inst
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .adc_data(adc_data),
    .adc_of(adc_of),
    .wr_en(buf_wr_en),
    .wr_addr(buf_wr_addr),
    .rd_addr(buf_rd_addr),
    .rd_data(buf_rdata),
    .adc_of_q(adc_of_q)
);

led_pwm led_pwm_inst
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .led(led_bus.pwm_side),
    .red_led(red_led),
    .green_led(green_led),
    .blue_led(blue_led)
);

irq_ctrl irq_ctrl_inst
(
    .led_clk(led_clk),
    .adc_dpram_rst(adc_dpram_rst),
    .capturing(capturing),
    .adc_of_q(adc_of_q),
    .irq_set(irq_set),
    .irq_clear(irq_clear),
    .smc_mask(smc_mask),
    .dsp_mask(dsp_mask),
    .irq_state(irq_state),
    .smc_irq_n(smc_irq_n),
    .dsp_irq_n(dsp_irq_n)
);

endmodule

// ==== verilog/radio_reg_block.sv ====
`timescale 1ns/10ps

`include "radio_ctrl_defs.svh"

module radio_reg_block
(
    input  logic                        led_clk,
    input  logic                        adc_dpram_rst,
    input  radio_ctrl_pkg::reg_addr_t   reg_addr,
    input  radio_ctrl_pkg::reg_data_t   reg_wdata,
    input  logic                        reg_wr_en,
    input  logic                        reg_rd_en,
    input  logic                        capturing,
    input  radio_ctrl_pkg::buf_addr_t   buf_wr_addr,
    input  radio_ctrl_pkg::buf_word_t   buf_rdata,
    input  radio_ctrl_pkg::irq_vec_t    irq_state,
    output radio_ctrl_pkg::reg_data_t   reg_rdata,
    output logic                        arm,
    output radio_ctrl_pkg::buf_addr_t   buf_rd_addr,
    output radio_ctrl_pkg::irq_vec_t    smc_mask,
    output radio_ctrl_pkg::irq_vec_t    dsp_mask,
    output radio_ctrl_pkg::irq_vec_t    irq_set,
    output radio_ctrl_pkg::irq_vec_t    irq_clear,
    led_ctrl_if.reg_side                led
);

import radio_ctrl_pkg::*;

localparam int ADDR_PAD = 16 - `RADIO_BUF_ASZ;
localparam int DUTY_PAD = 32 - `RADIO_PWM_W;

logic auto_inc; // Read address steps after each data read

always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            begin
                reg_rdata      <= '0;
                arm            <= 1'b0;
                auto_inc       <= 1'b0;
                buf_rd_addr    <= '0;
                smc_mask       <= '0;
                dsp_mask       <= '0;
                irq_set        <= '0;
                irq_clear      <= '0;
                led.led_en     <= 3'b000;
                led.red_duty   <= '0;
                led.green_duty <= '0;
                led.blue_duty  <= '0;
            end
        else
            begin
                // Requests retire once the target state is reached
                irq_clear <= irq_clear & irq_state;
                irq_set   <= irq_set & ~irq_state;
                arm       <= arm & ~capturing; // Drops once the fill has started

                if (reg_wr_en)
                    begin
                        case (reg_addr)
                            `REG_IRQ:
                                begin
                                    smc_mask  <= reg_wdata[7:0];
                                    dsp_mask  <= reg_wdata[15:8];
                                    irq_clear <= reg_wdata[23:16];
                                    irq_set   <= reg_wdata[31:24];
                                end
                            `REG_LED_CNTRL:  led.led_en     <= reg_wdata[2:0];
                            `REG_RED_DUTY:   led.red_duty   <= reg_wdata[`RADIO_PWM_W - 1:0];
                            `REG_GREEN_DUTY: led.green_duty <= reg_wdata[`RADIO_PWM_W - 1:0];
                            `REG_BLUE_DUTY:  led.blue_duty  <= reg_wdata[`RADIO_PWM_W - 1:0];
                            `REG_BUF_CNTRL:
                                begin
                                    arm      <= reg_wdata[0];
                                    auto_inc <= reg_wdata[1];
                                end
                            `REG_BUF_ADDR:   buf_rd_addr <= reg_wdata[`RADIO_BUF_ASZ - 1:0];
                            default: ; // ID and data are read only
                        endcase
                    end

                if (reg_rd_en)
                    begin
                        case (reg_addr)
                            `REG_ID:         reg_rdata <= `RADIO_CHIP_ID;
                            `REG_IRQ:        reg_rdata <= {8'd0, irq_state, dsp_mask, smc_mask};
                            `REG_LED_CNTRL:  reg_rdata <= {29'd0, led.led_en};
                            `REG_RED_DUTY:   reg_rdata <= {{DUTY_PAD{1'b0}}, led.red_duty};
                            `REG_GREEN_DUTY: reg_rdata <= {{DUTY_PAD{1'b0}}, led.green_duty};
                            `REG_BLUE_DUTY:  reg_rdata <= {{DUTY_PAD{1'b0}}, led.blue_duty};
                            `REG_BUF_CNTRL:  reg_rdata <= {29'd0, capturing, auto_inc, arm};
                            `REG_BUF_ADDR:
                                reg_rdata <= {{ADDR_PAD{1'b0}}, buf_wr_addr,
                                              {ADDR_PAD{1'b0}}, buf_rd_addr};
                            `REG_BUF_DATA:
                                begin
                                    reg_rdata <= {15'd0, buf_rdata};

                                    if (auto_inc)
                                        buf_rd_addr <= buf_rd_addr + 1'b1; // Wraps at 4K
                                end
                            default:         reg_rdata <= '0;
                        endcase
                    end
            end
    end

endmodule

// ==== verilog/sample_buffer.sv ====
`timescale 1ns/10ps

`include "radio_ctrl_defs.svh"

module sample_buffer
(
    input  logic                        led_clk,
    input  logic                        adc_dpram_rst,
    input  logic [`RADIO_SAMPLE_W - 1:0] adc_data,
    input  logic                        adc_of,
    input  logic                        wr_en,
    input  radio_ctrl_pkg::buf_addr_t   wr_addr,
    input  radio_ctrl_pkg::buf_addr_t   rd_addr,
    output radio_ctrl_pkg::buf_word_t   rd_data,
    output logic                        adc_of_q
);

import radio_ctrl_pkg::*;

logic [`RADIO_SAMPLE_W - 1:0] data_q;
buf_word_t                    mem [0:(1 << `RADIO_BUF_ASZ) - 1];

// Overflow flag feeds the IRQ edge detector
always_ff @(posedge led_clk)
    begin
        if (adc_dpram_rst)
            adc_of_q <= 1'b0;
        else
            adc_of_q <= adc_of;
    end

always_ff @(posedge led_clk)
    begin
        data_q <= adc_data;

        if (wr_en)
            mem[wr_addr] <= {adc_of_q, data_q}; // Sample from the previous cycle
    end

assign rd_data = mem[rd_addr]; // Asynchronous read port

endmodule
